// ==== list.f ====
source/cache_pkg.sv
source/mem_pkg.sv
source/dcache_controller.sv
source/tag_array.sv
source/line_store.sv
source/burst_buffer.sv
source/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_dcache
FILE_LIST = list.f
PASS_TEXT = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    localparam int index_bits  = 4;
    localparam int offset_bits = 2;
    localparam int line_words  = 2 ** offset_bits;
    localparam int max_delay   = 3;
    localparam int random_accesses   = 60;
    localparam int directed_accesses = 11;
    // write-back plus refill, every beat at its longest address and data wait
    localparam int dirty_miss_cycles = 2 * line_words * (2 * max_delay + 2) + 4;
    localparam int cycle_limit =
        (random_accesses + directed_accesses) * (dirty_miss_cycles + 2) + 50;

    logic                clk = 1'b0;
    logic                reset;
    logic                cpu_req;
    cache_pkg::cpu_req_t cpu_cmd;
    cache_pkg::word_t    cpu_rdata;
    logic                cpu_data_ok;
    logic                mem_req;
    mem_pkg::mem_cmd_t   mem_cmd;
    logic                mem_addr_ok;
    logic                mem_data_ok;
    cache_pkg::word_t    mem_rdata;

    logic [15:0]         lfsr = 16'd10957;
    cache_pkg::word_t    shadow [mem_pkg::mem_addr_t];
    cache_pkg::tag_t     model_tag [2 ** index_bits];
    logic                model_valid [2 ** index_bits];
    logic                model_dirty [2 ** index_bits];
    mem_pkg::mem_cmd_t   beats [$];    // expected memory beats in order
    mem_pkg::mem_cmd_t   exp_beat;
    int                  beats_left;
    logic                req_seen, req_start, exp_hit;
    cache_pkg::word_t    expect_word;
    int errors, errors_at_start, test_no, requests, responses, cycles;

    always #20 clk = ~clk;

    dcache_top #(.index_bits(index_bits), .offset_bits(offset_bits)) i_dcache_top (
        .clk, .reset, .cpu_req, .cpu_cmd, .cpu_rdata, .cpu_data_ok, .mem_req, .mem_cmd,
        .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    mem_model #(.max_delay(max_delay), .seed(16'd10957)) i_mem_model (
        .clk, .reset, .mem_req, .mem_cmd, .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    task automatic value_error(string msg);
        errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic protocol_error(string msg);
        errors++;
        $display("at %0d ns %s", $time, msg);
    endtask

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 16'hb400;    // galois taps
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    function automatic cache_pkg::word_t shadow_word(mem_pkg::mem_addr_t a);
        return shadow.exists(a) ? shadow[a] : {a, 2'b11} * 32'h9e37_79b1;
    endfunction

    // byte lanes follow the size and the low address bits
    function automatic cache_pkg::word_t merge_store(cache_pkg::word_t old,
            cache_pkg::access_size_e size, logic [1:0] lane, cache_pkg::word_t data);
        cache_pkg::word_t result;
        int               b;
        result = old;
        b = int'(lane);
        case (size)
            cache_pkg::size_byte: result[b*8 +: 8] = data[b*8 +: 8];
            cache_pkg::size_half: begin
                if (lane[1]) result[31:16] = data[31:16];
                else result[15:0] = data[15:0];
            end
            default: result = data;
        endcase
        return result;
    endfunction

    task automatic access(logic we, cache_pkg::access_size_e size, cache_pkg::addr_t addr,
            cache_pkg::word_t wdata);
        cache_pkg::index_t  set;
        cache_pkg::tag_t    tag;
        mem_pkg::mem_addr_t word_addr;
        mem_pkg::mem_addr_t a;
        set = addr[2 + offset_bits +: index_bits];
        tag = addr[31 : 2 + offset_bits + index_bits];
        word_addr = addr[31:2];
        exp_hit = model_valid[set] && model_tag[set] == tag;
        if (!exp_hit) begin
            if (model_valid[set] && model_dirty[set]) begin
                for (int w = 0; w < line_words; w++) begin
                    a = {model_tag[set], set, cache_pkg::offset_t'(w)};
                    beats.push_back({1'b1, a, shadow_word(a)});
                end
            end
            for (int w = 0; w < line_words; w++) begin
                beats.push_back({1'b0, tag, set, cache_pkg::offset_t'(w), 32'h0});
            end
            model_valid[set] = 1'b1;
            model_tag[set]   = tag;
            model_dirty[set] = 1'b0;
            exp_beat   = beats[0];
            beats_left = beats.size();
        end
        if (we) begin
            shadow[word_addr] = merge_store(shadow_word(word_addr), size, addr[1:0], wdata);
            model_dirty[set]  = 1'b1;
        end else begin
            expect_word = shadow_word(word_addr);
        end
        cpu_cmd.we    = we;
        cpu_cmd.size  = size;
        cpu_cmd.addr  = addr;
        cpu_cmd.wdata = wdata;
        cpu_req   = 1'b1;
        req_seen  = 1'b1;
        req_start = 1'b1;
        requests++;
        @(posedge clk);
        #1 req_start = 1'b0;
        while (!cpu_data_ok) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1 cpu_req = 1'b0;
    endtask

    task automatic random_access();
        logic [31:0]             r;
        cache_pkg::access_size_e size;
        logic [1:0]              lane;
        logic                    we;
        r  = rand_bits(1);
        we = r[0];
        r  = rand_bits(2);
        size = r[1:0] == 2'd0 ? cache_pkg::size_byte
             : r[1:0] == 2'd1 ? cache_pkg::size_half : cache_pkg::size_word;
        r = rand_bits(2);
        lane = size == cache_pkg::size_byte ? r[1:0]
             : size == cache_pkg::size_half ? {r[0], 1'b0} : 2'b00;
        r = rand_bits(8);    // two tag bits, two index bits, word offset
        access(we, size, {22'h0a5, r[7:6], 2'b00, r[5:4], r[3:2], lane}, rand_bits(32));
    endtask

    task automatic end_test(string name);
        $display("test %0d %s: %0d errors", test_no, name, errors - errors_at_start);
        test_no++;
        errors_at_start = errors;
    endtask

    // beat bookkeeping, popped as each address beat is accepted
    always @(posedge clk) begin
        if (!reset && mem_req && mem_addr_ok && beats.size() > 0) begin
            void'(beats.pop_front());
            beats_left = beats.size();
            if (beats.size() > 0) exp_beat = beats[0];
        end
        if (!reset && cpu_data_ok) responses++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, the run was stopped after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !req_seen |-> !mem_req && !cpu_data_ok)
        else protocol_error("memory request or response came before the first access");

    a_read_data: assert property (@(posedge clk) disable iff (reset)
        cpu_data_ok && !cpu_cmd.we |-> cpu_rdata == expect_word)
        else value_error($sformatf("read of %h returned %h, expected %h",
                                   cpu_cmd.addr, cpu_rdata, expect_word));

    a_beat_expected: assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_addr_ok |-> beats_left > 0)
        else protocol_error("memory beat was issued that no miss needs");

    a_beat_addr: assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_addr_ok |-> mem_cmd.we == exp_beat.we && mem_cmd.addr == exp_beat.addr)
        else value_error($sformatf("beat address %h, expected %h", mem_cmd.addr, exp_beat.addr));

    a_beat_wdata: assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_addr_ok && mem_cmd.we |-> mem_cmd.wdata == exp_beat.wdata)
        else value_error($sformatf("write-back of %h sent %h, expected %h",
                                   mem_cmd.addr, mem_cmd.wdata, exp_beat.wdata));

    a_req_drops: assert property (@(posedge clk) disable iff (reset)
        mem_req && mem_addr_ok && (&exp_beat.addr[offset_bits-1:0]) |=> !mem_req)
        else protocol_error("mem_req stayed high after the last address beat");

    a_hit_latency: assert property (@(posedge clk) disable iff (reset)
        cpu_req && req_start && exp_hit |=> cpu_data_ok)
        else protocol_error("hit did not answer one clock after the request");

    a_hit_no_mem: assert property (@(posedge clk) disable iff (reset)
        cpu_req && exp_hit |-> !mem_req)
        else protocol_error("hit raised a memory request");

    a_single_response: assert property (@(posedge clk) disable iff (reset)
        cpu_data_ok |-> cpu_req ##1 !cpu_data_ok)
        else protocol_error("response without a request or longer than one cycle");

    initial begin
        cache_pkg::addr_t a;
        cache_pkg::addr_t b;
        reset = 1'b1;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        req_seen = 1'b0;
        req_start = 1'b0;
        exp_hit = 1'b0;
        expect_word = '0;
        exp_beat = '0;
        beats_left = 0;
        errors = 0;
        errors_at_start = 0;
        test_no = 1;
        requests = 0;
        responses = 0;
        cycles = 0;
        for (int s = 0; s < 2 ** index_bits; s++) begin
            model_tag[s]   = '0;
            model_valid[s] = 1'b0;
            model_dirty[s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        end_test("reset state");

        a = {22'h0a5, 2'b01, 4'h6, 2'b00, 2'b00};
        b = {22'h0a5, 2'b10, 4'h6, 2'b00, 2'b00};    // same set, other tag
        access(1'b0, cache_pkg::size_word, a, '0);
        end_test("read miss");
        access(1'b0, cache_pkg::size_word, a + 32'd8, '0);
        access(1'b0, cache_pkg::size_word, a, '0);
        end_test("read hit");
        access(1'b1, cache_pkg::size_byte, a + 32'd1, 32'h0000_5a00);
        access(1'b1, cache_pkg::size_half, a + 32'd6, 32'hbeef_0000);
        access(1'b1, cache_pkg::size_word, a + 32'd12, 32'h1234_5678);
        access(1'b0, cache_pkg::size_word, a, '0);
        access(1'b0, cache_pkg::size_word, a + 32'd4, '0);
        access(1'b0, cache_pkg::size_word, a + 32'd12, '0);
        end_test("store merge");
        access(1'b0, cache_pkg::size_word, b, '0);
        access(1'b0, cache_pkg::size_word, a + 32'd4, '0);
        end_test("dirty eviction");
        for (int i = 0; i < random_accesses; i++) begin
            random_access();
        end
        repeat (2) @(posedge clk);
        #1;
        assert (responses == requests)
            else protocol_error($sformatf("%0d responses for %0d requests", responses, requests));
        end_test("random delays");

        $display("%0d tests, %0d requests, %0d errors", test_no - 1, requests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int          max_delay = 3,
    parameter logic [15:0] seed      = 16'd10957
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_req,
    input  mem_pkg::mem_cmd_t  mem_cmd,
    output logic               mem_addr_ok,
    output logic               mem_data_ok,
    output mem_pkg::mem_word_t mem_rdata
);

    mem_pkg::mem_word_t mem [mem_pkg::mem_addr_t];
    mem_pkg::mem_cmd_t  pending [$];    // accepted beats waiting for data
    logic [15:0]        lfsr = seed;
    int                 addr_wait;
    int                 data_wait;

    // two lfsr bits per delay
    function automatic int delay_draw();
        int  d;
        logic lsb;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 16'hb400;
            d = d * 2 + int'(lsb);
        end
        return d % (max_delay + 1);
    endfunction

    // untouched words follow a pattern of the whole address
    function automatic mem_pkg::mem_word_t read_word(mem_pkg::mem_addr_t a);
        return mem.exists(a) ? mem[a] : {a, 2'b11} * 32'h9e37_79b1;
    endfunction

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        addr_wait   = 0;
        data_wait   = 0;
        forever begin
            @(posedge clk);
            if (reset) begin
                pending.delete();
                addr_wait = 0;
                data_wait = 0;
            end else begin
                if (mem_req && mem_addr_ok) begin
                    if (mem_cmd.we) mem[mem_cmd.addr] = mem_cmd.wdata;    // write-back beat
                    pending.push_back(mem_cmd);
                    addr_wait = delay_draw();
                end else if (addr_wait > 0) begin
                    addr_wait--;
                end
                if (mem_data_ok) begin
                    void'(pending.pop_front());
                    data_wait = delay_draw();
                end else if (pending.size() > 0 && data_wait > 0) begin
                    data_wait--;
                end
            end
            #1;
            mem_addr_ok = !reset && mem_req && addr_wait == 0;
            mem_data_ok = !reset && pending.size() > 0 && data_wait == 0;
            if (mem_data_ok && !pending[0].we) mem_rdata = read_word(pending[0].addr);
            else mem_rdata = '0;
        end
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cpu_req,
    input  cache_pkg::cpu_req_t cpu_cmd,
    output cache_pkg::word_t    cpu_rdata,
    output logic                cpu_data_ok,
    output logic                mem_req,
    output mem_pkg::mem_cmd_t   mem_cmd,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    input  cache_pkg::word_t    mem_rdata
);

    cache_pkg::index_t  req_index;
    cache_pkg::tag_t    req_tag;
    cache_pkg::offset_t req_offset;
    cache_pkg::offset_t beat_offset;
    cache_pkg::offset_t line_offset;
    cache_pkg::tag_t    victim_tag;
    mem_pkg::mem_addr_t line_base;
    logic               hit, victim_dirty, addr_done, data_done;
    logic               tag_write, set_dirty, store_write, fill_write;
    logic               burst_start, burst_write, burst_active;

    // request address split
    assign req_offset = cpu_cmd.addr[2 +: offset_bits];
    assign req_index  = cpu_cmd.addr[2 + offset_bits +: index_bits];
    assign req_tag    = cpu_cmd.addr[31 : 2 + offset_bits + index_bits];

    // victim line during write-back, requested line during refill
    assign line_base = burst_write ? {victim_tag, req_index, {offset_bits{1'b0}}}
                                   : {req_tag, req_index, {offset_bits{1'b0}}};
    assign line_offset = burst_active ? beat_offset : req_offset;

    dcache_controller i_dcache_controller (
        .clk, .reset, .cpu_req, .cpu_we(cpu_cmd.we), .hit, .victim_dirty,
        .addr_done, .data_done, .cpu_data_ok, .mem_req, .tag_write, .set_dirty,
        .store_write, .fill_write, .burst_start, .burst_write, .burst_active
    );

    tag_array #(.index_bits(index_bits)) i_tag_array (
        .clk, .reset, .index(req_index), .tag(req_tag), .tag_write, .set_dirty,
        .hit, .victim_dirty, .victim_tag
    );

    line_store #(.index_bits(index_bits), .offset_bits(offset_bits)) i_line_store (
        .clk, .index(req_index), .offset(line_offset), .size(cpu_cmd.size),
        .byte_sel(cpu_cmd.addr[1:0]), .wdata(cpu_cmd.wdata), .store_write,
        .fill_write(fill_write && mem_data_ok),    // one word per data beat
        .fill_data(mem_rdata), .rdata(cpu_rdata)
    );

    burst_buffer #(.offset_bits(offset_bits)) i_burst_buffer (
        .clk, .reset, .burst_start, .burst_write, .burst_active, .line_base,
        .line_data(cpu_rdata), .mem_addr_ok, .mem_data_ok, .mem_cmd, .beat_offset,
        .addr_done, .data_done
    );

endmodule

// ==== source/burst_buffer.sv ====
`timescale 1ns/1ps

module burst_buffer #(
    parameter int offset_bits = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                burst_start,
    input  logic                burst_write,
    input  logic                burst_active,
    input  mem_pkg::mem_addr_t  line_base,
    input  cache_pkg::word_t    line_data,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    output mem_pkg::mem_cmd_t   mem_cmd,
    output cache_pkg::offset_t  beat_offset,
    output logic                addr_done,
    output logic                data_done
);

    // address beats count to the full line, the extra bit marks all issued
    logic [offset_bits:0]   addr_cnt;
    logic [offset_bits-1:0] data_cnt;
    logic                   data_last;

    always_ff @(posedge clk) begin
        if (reset || burst_start) begin
            addr_cnt <= '0;
        end else if (burst_active && mem_addr_ok && !addr_done) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // data beats may trail the address beats by any number of cycles
    always_ff @(posedge clk) begin
        if (reset || burst_start) begin
            data_cnt <= '0;
        end else if (burst_active && mem_data_ok) begin
            data_cnt <= data_cnt + 1'b1;    // wraps after the last beat
        end
    end

    assign addr_done = addr_cnt[offset_bits];
    assign data_last = &data_cnt;
    assign data_done = burst_active && mem_data_ok && data_last;

    // beat address, line base has zero offset bits
    always_comb begin
        mem_cmd.we    = burst_write;
        mem_cmd.addr  = {line_base[$bits(mem_pkg::mem_addr_t)-1:offset_bits],
                         addr_cnt[offset_bits-1:0]};
        mem_cmd.wdata = line_data;
    end

    // write-back reads the word of the address beat, refill writes the data beat
    assign beat_offset = burst_write ? addr_cnt[offset_bits-1:0] : data_cnt;

endmodule

// ==== source/line_store.sv ====
`timescale 1ns/1ps

module line_store #(
    parameter int index_bits  = 4,
    parameter int offset_bits = 2
) (
    input  logic                    clk,
    input  cache_pkg::index_t       index,
    input  cache_pkg::offset_t      offset,
    input  cache_pkg::access_size_e size,
    input  logic [1:0]              byte_sel,
    input  cache_pkg::word_t        wdata,
    input  logic                    store_write,
    input  logic                    fill_write,
    input  cache_pkg::word_t        fill_data,
    output cache_pkg::word_t        rdata
);

    localparam int words = 2 ** (index_bits + offset_bits);

    cache_pkg::word_t                    data_mem [words];
    logic [index_bits+offset_bits-1:0]   word_addr;
    logic [3:0]                          byte_en;

    assign word_addr = {index, offset};

    // lanes touched by a store
    always_comb begin
        case (size)
            cache_pkg::size_byte: byte_en = 4'b0001 << byte_sel;
            cache_pkg::size_half: byte_en = byte_sel[1] ? 4'b1100 : 4'b0011;
            default:              byte_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            data_mem[word_addr] <= fill_data;    // whole refill word
        end else if (store_write) begin
            // wdata already lane aligned, only the enabled bytes merge in
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    data_mem[word_addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read, feeds both cpu_rdata and write-back data
    assign rdata = data_mem[word_addr];

    // the controller keeps stores in respond and fills in refill
    a_no_store_during_fill: assert property (
        @(posedge clk) !(store_write && fill_write)
    );

endmodule

// ==== source/tag_array.sv ====
`timescale 1ns/1ps

module tag_array #(
    parameter int index_bits = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  logic              tag_write,
    input  logic              set_dirty,
    output logic              hit,
    output logic              victim_dirty,
    output cache_pkg::tag_t   victim_tag
);

    localparam int sets = 2 ** index_bits;

    logic [sets-1:0]  valid;
    logic [sets-1:0]  dirty;
    cache_pkg::tag_t  tags [sets];

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_write) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;    // freshly filled line is clean
        end else if (set_dirty) begin
            dirty[index] <= 1'b1;
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[index] <= tag;
        end
    end

    assign hit          = valid[index] && (tags[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag   = tags[index];    // builds the write-back address

endmodule

// ==== source/dcache_controller.sv ====
`timescale 1ns/1ps

module dcache_controller (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic cpu_we,
    input  logic hit,
    input  logic victim_dirty,
    input  logic addr_done,
    input  logic data_done,
    output logic cpu_data_ok,
    output logic mem_req,
    output logic tag_write,
    output logic set_dirty,
    output logic store_write,
    output logic fill_write,
    output logic burst_start,
    output logic burst_write,
    output logic burst_active
);

    typedef enum logic [1:0] {
        idle,
        write_back,
        refill,
        respond
    } state_e;

    state_e state;
    state_e state_next;
    logic   miss;

    assign miss = cpu_req && !hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (miss) begin
                    // dirty victim has to go out before the new line comes in
                    state_next = victim_dirty ? write_back : refill;
                end else if (cpu_req) begin
                    state_next = respond;
                end
            end
            write_back: begin
                if (data_done) begin
                    state_next = refill;    // last write acknowledged
                end
            end
            refill: begin
                if (data_done) begin
                    state_next = respond;
                end
            end
            respond: begin
                state_next = idle;    // one-cycle answer
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // counters restart on the miss and again between write-back and refill
    assign burst_start  = (state == idle && miss) || (state == write_back && data_done);
    assign burst_write  = (state == write_back);
    assign burst_active = (state == write_back) || (state == refill);

    // request level stays up until the last address beat is taken
    assign mem_req = burst_active && !addr_done;

    assign fill_write = (state == refill);    // qualified by mem_data_ok in the top
    assign tag_write  = (state == refill) && data_done;

    // a miss replays through respond, so stores always merge into a resident line
    assign store_write = (state == respond) && cpu_we;
    assign set_dirty   = store_write;
    assign cpu_data_ok = (state == respond);

    a_idle_no_mem_req: assert property (
        @(posedge clk) disable iff (reset)
        state == idle |-> !mem_req
    );

    // the refilled tag must already match when the access is replayed
    a_respond_hits: assert property (
        @(posedge clk) disable iff (reset)
        state == respond |-> hit
    );

endmodule

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // the memory port moves one 32-bit word per beat
    localparam int mem_word_bits = 32;
    localparam int mem_addr_bits = 30;    // word address, byte bits dropped

    typedef logic [mem_addr_bits-1:0] mem_addr_t;
    typedef logic [mem_word_bits-1:0] mem_word_t;

    // command presented with mem_req, one per address beat
    // wdata only matters on write-back beats
    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        mem_word_t wdata;
    } mem_cmd_t;

endpackage

// ==== source/cache_pkg.sv ====
package cache_pkg;

    // geometry defaults, dcache_top passes the same values down as parameters
    localparam int word_bits   = 32;
    localparam int byte_bits   = 2;    // byte lane select inside a word
    localparam int index_bits  = 4;    // 16 sets
    localparam int offset_bits = 2;    // 4 words per line
    localparam int tag_bits    = word_bits - index_bits - offset_bits - byte_bits;

    typedef logic [word_bits-1:0]   word_t;
    typedef logic [word_bits-1:0]   addr_t;    // byte address
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] offset_t;  // word inside the line

    // access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    // one processor request, held stable until cpu_data_ok
    // store data sits on its own byte lanes, as the address selects them
    typedef struct packed {
        logic         we;
        access_size_e size;
        addr_t        addr;
        word_t        wdata;
    } cpu_req_t;

endpackage
